//--- Makefile
# Verilator build and run of the branch predictor testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_branch_predictor
FILELIST = all.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "test: failure found in $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || (echo "test: run ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- all.f
+incdir+include
src/rv_isa_pkg.sv
src/bp_pkg.sv
src/btb.sv
src/gshare.sv
src/predict_pipe.sv
src/branch_resolve.sv
src/branch_predictor.sv
tests/bp_properties.sv
tests/tb_branch_predictor.sv

//--- include/bp_consts.svh
// table sizes must be powers of two; PCs are assumed 4-byte aligned so bits [1:0] are never indexed
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// number of branch target buffer entries
`define BP_BTB_ENTRIES 32

// global history length, also the width of the counter table index
// the counter table holds 2**BP_GHR_BITS entries
`define BP_GHR_BITS 5

// counter value loaded into every table entry on reset
// 2'b01 is weakly not taken, so a fresh branch needs one taken outcome to flip
`define BP_CTR_INIT 2'b01

`endif

//--- src/bp_pkg.sv
// widths follow bp_consts.svh; counter encoding keeps the taken prediction in the MSB
`include "bp_consts.svh"

package bp_pkg;

    // BTB index, taken from the PC bits right above the byte offset
    typedef logic [$clog2(`BP_BTB_ENTRIES)-1:0] btb_idx_t;

    // global history register, doubles as the counter table index
    typedef logic [`BP_GHR_BITS-1:0] ghr_t;

    // 2-bit saturating counter
    typedef enum logic [1:0] {
        CTR_STRONG_NT = 2'b00,
        CTR_WEAK_NT   = 2'b01,
        CTR_WEAK_T    = 2'b10,
        CTR_STRONG_T  = 2'b11
    } ctr_t;

endpackage

//--- src/branch_predictor.sv
// prediction is combinational from pc_f_i; the pipeline must redirect fetch on mispredict_o
module branch_predictor
    import rv_isa_pkg::*, bp_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  logic    stall_i,
    input  pc_t     pc_f_i,
    input  opcode_t op_e_i,
    input  logic    taken_e_i,
    input  pc_t     target_e_i,
    output logic    taken_o,
    output pc_t     target_o,
    output logic    mispredict_o,
    output pc_t     redirect_pc_o
);

    logic btb_hit;
    logic btb_jump;
    pc_t  btb_target;
    logic ctr_taken;
    ghr_t pht_index;

    logic valid_e;
    pc_t  pc_e;
    logic hit_e;
    logic pred_taken_e;
    pc_t  pred_target_e;
    ghr_t idx_e;

    logic btb_fill;
    logic btb_fill_jump;
    logic pht_update;
    logic pht_increment;
    ghr_t pht_idx;

    btb btb_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .pc_i          (pc_f_i),
        .fill_i        (btb_fill),
        .fill_pc_i     (pc_e),
        .fill_target_i (target_e_i),
        .fill_jump_i   (btb_fill_jump),
        .hit_o         (btb_hit),
        .jump_o        (btb_jump),
        .target_o      (btb_target)
    );

    gshare gshare_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .pc_i            (pc_f_i),
        .update_i        (pht_update),
        .update_idx_i    (pht_idx),
        .increment_i     (pht_increment),
        .predict_taken_o (ctr_taken),
        .index_o         (pht_index)
    );

    // jumps that hit are always taken, branches follow their counter
    assign taken_o  = btb_hit && (btb_jump || ctr_taken);
    // the target rides along on every hit so execute can spot a stale entry
    assign target_o = btb_target;

    predict_pipe predict_pipe_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .stall_i    (stall_i),
        .flush_i    (mispredict_o),
        .pc_f_i     (pc_f_i),
        .hit_f_i    (btb_hit),
        .taken_f_i  (taken_o),
        .target_f_i (target_o),
        .idx_f_i    (pht_index),
        .valid_e_o  (valid_e),
        .pc_e_o     (pc_e),
        .hit_e_o    (hit_e),
        .taken_e_o  (pred_taken_e),
        .target_e_o (pred_target_e),
        .idx_e_o    (idx_e)
    );

    branch_resolve branch_resolve_i (
        .valid_e_i       (valid_e),
        .pc_e_i          (pc_e),
        .hit_e_i         (hit_e),
        .pred_taken_i    (pred_taken_e),
        .pred_target_i   (pred_target_e),
        .idx_e_i         (idx_e),
        .stall_i         (stall_i),
        .op_i            (op_e_i),
        .taken_i         (taken_e_i),
        .target_i        (target_e_i),
        .mispredict_o    (mispredict_o),
        .redirect_pc_o   (redirect_pc_o),
        .btb_fill_o      (btb_fill),
        .btb_fill_jump_o (btb_fill_jump),
        .pht_update_o    (pht_update),
        .pht_increment_o (pht_increment),
        .pht_idx_o       (pht_idx)
    );

endmodule

//--- src/branch_resolve.sv
// outcome inputs count only while the execute entry is valid; nothing fires during a stall
module branch_resolve
    import rv_isa_pkg::*, bp_pkg::*;
(
    // prediction carried to execute
    input  logic    valid_e_i,
    input  pc_t     pc_e_i,
    input  logic    hit_e_i,
    input  logic    pred_taken_i,
    input  pc_t     pred_target_i,
    input  ghr_t    idx_e_i,
    input  logic    stall_i,
    // resolved outcome
    input  opcode_t op_i,
    input  logic    taken_i,
    input  pc_t     target_i,
    output logic    mispredict_o,
    output pc_t     redirect_pc_o,
    output logic    btb_fill_o,
    output logic    btb_fill_jump_o,
    output logic    pht_update_o,
    output logic    pht_increment_o,
    output ghr_t    pht_idx_o
);

    logic active;
    logic is_branch;
    logic is_jump;
    logic actual_taken;
    logic target_wrong;

    assign active    = valid_e_i && !stall_i;
    assign is_branch = (op_i == OP_BRANCH);
    assign is_jump   = (op_i == OP_JAL) || (op_i == OP_JALR);

    // jumps always transfer, non control instructions never do
    assign actual_taken = is_jump || (is_branch && taken_i);
    assign target_wrong = (pred_target_i != target_i);

    assign mispredict_o = active && ((pred_taken_i != actual_taken) ||
                                     (pred_taken_i && actual_taken && target_wrong));

    assign redirect_pc_o = actual_taken ? target_i : pc_e_i + 32'd4;

    // new entry on a miss, correction when the stored target went stale
    assign btb_fill_o      = active && actual_taken && (!hit_e_i || target_wrong);
    assign btb_fill_jump_o = is_jump;

    assign pht_update_o    = active && is_branch;
    assign pht_increment_o = taken_i;
    assign pht_idx_o       = idx_e_i;

endmodule

//--- src/btb.sv
// direct mapped with a full-PC tag; a fill in the lookup cycle wins over the stored entry
`include "bp_consts.svh"

module btb
    import rv_isa_pkg::*, bp_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    // fetch lookup
    input  pc_t  pc_i,
    // fill or correction from execute
    input  logic fill_i,
    input  pc_t  fill_pc_i,
    input  pc_t  fill_target_i,
    input  logic fill_jump_i,
    output logic hit_o,
    output logic jump_o,
    output pc_t  target_o
);

    localparam int ENTRIES  = `BP_BTB_ENTRIES;
    localparam int IDX_BITS = $bits(btb_idx_t);

    logic valid_q  [ENTRIES];
    pc_t  tag_q    [ENTRIES];
    pc_t  target_q [ENTRIES];
    logic jump_q   [ENTRIES];

    btb_idx_t lookup_idx;
    btb_idx_t fill_idx;
    logic     fill_same_idx;

    assign lookup_idx    = pc_i[IDX_BITS+1:2];
    assign fill_idx      = fill_pc_i[IDX_BITS+1:2];
    assign fill_same_idx = fill_i && (fill_idx == lookup_idx);

    always_comb begin
        if (fill_same_idx) begin
            // forward the entry as it will look after this edge
            hit_o    = (fill_pc_i == pc_i);
            jump_o   = fill_jump_i;
            target_o = fill_target_i;
        end else begin
            hit_o    = valid_q[lookup_idx] && (tag_q[lookup_idx] == pc_i);
            jump_o   = jump_q[lookup_idx];
            target_o = target_q[lookup_idx];
        end
    end

    // valid bits are the only control state in the table
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill_i) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tag_q[fill_idx]    <= fill_pc_i;
            target_q[fill_idx] <= fill_target_i;
            jump_q[fill_idx]   <= fill_jump_i;
        end
    end

endmodule

//--- src/gshare.sv
// updates land on the next edge with no bypass; history shifts only on resolved conditional branches
`include "bp_consts.svh"

module gshare
    import rv_isa_pkg::*, bp_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    input  pc_t  pc_i,
    // resolved conditional branch from execute
    input  logic update_i,
    input  ghr_t update_idx_i,
    input  logic increment_i,
    output logic predict_taken_o,
    output ghr_t index_o
);

    localparam int BITS    = `BP_GHR_BITS;
    localparam int ENTRIES = 1 << BITS;

    ctr_t pht_q [ENTRIES];
    ghr_t ghr_q;
    ctr_t cur_ctr;

    // saturating step toward taken or not taken
    function automatic ctr_t ctr_next(ctr_t c, logic inc);
        ctr_t n;
        n = c;
        case (c)
            CTR_STRONG_NT: n = inc ? CTR_WEAK_NT : CTR_STRONG_NT;
            CTR_WEAK_NT:   n = inc ? CTR_WEAK_T  : CTR_STRONG_NT;
            CTR_WEAK_T:    n = inc ? CTR_STRONG_T : CTR_WEAK_NT;
            CTR_STRONG_T:  n = inc ? CTR_STRONG_T : CTR_WEAK_T;
            default:       n = ctr_t'(`BP_CTR_INIT);
        endcase
        return n;
    endfunction

    assign index_o         = pc_i[BITS+1:2] ^ ghr_q;
    assign cur_ctr         = pht_q[index_o];
    assign predict_taken_o = (cur_ctr == CTR_WEAK_T) || (cur_ctr == CTR_STRONG_T);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < ENTRIES; i++) begin
                pht_q[i] <= ctr_t'(`BP_CTR_INIT);
            end
        end else if (update_i) begin
            pht_q[update_idx_i] <= ctr_next(pht_q[update_idx_i], increment_i);
        end
    end

    // the real outcome goes in, not the prediction
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ghr_q <= '0;
        end else if (update_i) begin
            ghr_q <= {ghr_q[BITS-2:0], increment_i};
        end
    end

endmodule

//--- src/predict_pipe.sv
// fetch is assumed to present a valid PC every unstalled cycle; flush wins over stall
module predict_pipe
    import rv_isa_pkg::*, bp_pkg::*;
(
    input  logic clk,
    input  logic reset_i,
    input  logic stall_i,
    input  logic flush_i,
    // prediction made in fetch
    input  pc_t  pc_f_i,
    input  logic hit_f_i,
    input  logic taken_f_i,
    input  pc_t  target_f_i,
    input  ghr_t idx_f_i,
    // prediction seen by execute
    output logic valid_e_o,
    output pc_t  pc_e_o,
    output logic hit_e_o,
    output logic taken_e_o,
    output pc_t  target_e_o,
    output ghr_t idx_e_o
);

    logic valid_d_q;
    pc_t  pc_d_q;
    logic hit_d_q;
    logic taken_d_q;
    pc_t  target_d_q;
    ghr_t idx_d_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_d_q <= 1'b0;
            valid_e_o <= 1'b0;
        end else if (flush_i) begin
            // both younger entries are on the wrong path
            valid_d_q <= 1'b0;
            valid_e_o <= 1'b0;
        end else if (!stall_i) begin
            valid_d_q <= 1'b1;
            valid_e_o <= valid_d_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_d_q     <= pc_f_i;
            hit_d_q    <= hit_f_i;
            taken_d_q  <= taken_f_i;
            target_d_q <= target_f_i;
            idx_d_q    <= idx_f_i;
            pc_e_o     <= pc_d_q;
            hit_e_o    <= hit_d_q;
            taken_e_o  <= taken_d_q;
            target_e_o <= target_d_q;
            idx_e_o    <= idx_d_q;
        end
    end

endmodule

//--- src/rv_isa_pkg.sv
// covers only the RV32I opcodes the predictor distinguishes; all others map to OP_OTHER
package rv_isa_pkg;

    // byte address of an instruction
    typedef logic [31:0] pc_t;

    // major opcode field, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        // conditional branches BEQ..BGEU
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        // indirect jump, target may change between executions
        OP_JALR   = 7'b1100111,
        // stands in for every non control transfer instruction
        OP_OTHER  = 7'b0010011
    } opcode_t;

endpackage

//--- tests/bp_properties.sv
// bound to branch_predictor; reaches the execute entry through internal nets of the top level
module bp_properties
    import rv_isa_pkg::*;
(
    input logic clk,
    input logic reset_i,
    input pc_t  pc_e,
    input logic pred_taken_e,
    input pc_t  target_e_i,
    input logic taken_o,
    input logic mispredict_o,
    input pc_t  redirect_pc_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // tables are empty while reset is held and on the first cycle after it
    no_taken_after_reset: assert property (@(posedge clk) reset_i |=> !taken_o)
        else $error("taken_o high during or right after reset");

    // execute stays empty for two cycles after reset or a flush
    mispredict_needs_entry: assert property (@(posedge clk) disable iff (reset_i)
        ($past(reset_i) || $past(reset_i, 2) || $past(mispredict_o) || $past(mispredict_o, 2))
        |-> !mispredict_o)
        else $error("mispredict_o while the execute stage holds no entry");

    // a fall through redirect only undoes a taken prediction
    redirect_target: assert property (@(posedge clk) disable iff (reset_i)
        mispredict_o |-> (redirect_pc_o == target_e_i) ||
                         (pred_taken_e && (redirect_pc_o == pc_e + 32'd4)))
        else $error("redirect_pc_o does not match the resolved direction");

endmodule

bind branch_predictor bp_properties bp_properties_i (
    .clk           (clk),
    .reset_i       (reset_i),
    .pc_e          (pc_e),
    .pred_taken_e  (pred_taken_e),
    .target_e_i    (target_e_i),
    .taken_o       (taken_o),
    .mispredict_o  (mispredict_o),
    .redirect_pc_o (redirect_pc_o)
);

//--- tests/tb_branch_predictor.sv
// models the in-order pipe and reference tables; the instruction stream need not follow predictions
`include "bp_consts.svh"

module tb_branch_predictor
    import rv_isa_pkg::*, bp_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic    valid;
        pc_t     pc;
        opcode_t op;
        logic    taken;
        pc_t     target;
        logic    hit;
        logic    ptaken;
        pc_t     ptarget;
        ghr_t    idx;
    } slot_t;

    logic clk, reset_i, stall_i, taken_e_i, taken_o, mispredict_o;
    pc_t pc_f_i, target_e_i, target_o, redirect_pc_o;
    opcode_t op_e_i;

    logic m_valid [`BP_BTB_ENTRIES];
    pc_t  m_tag   [`BP_BTB_ENTRIES];
    pc_t  m_tgt   [`BP_BTB_ENTRIES];
    logic m_jump  [`BP_BTB_ENTRIES];
    ctr_t m_ctr   [1 << `BP_GHR_BITS];
    ghr_t m_ghr;
    slot_t d_s, e_s;
    int errors, tests, test_err0, nop_count;
    string test_name;

    branch_predictor branch_predictor_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(string what, logic [31:0] exp, logic [31:0] act);
        assert (exp == act) else begin
            $display("Fail %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    // one pipeline cycle, entered 1 ns after a rising edge
    task automatic step(pc_t pc, opcode_t op, logic tk, pc_t tgt, logic stall);
        slot_t f;
        logic active, actual, mis, fill, jmp;
        btb_idx_t fi, li;
        active = e_s.valid && !stall;
        actual = (e_s.op == OP_JAL) || (e_s.op == OP_JALR) || (e_s.op == OP_BRANCH && e_s.taken);
        mis = active && ((e_s.ptaken != actual) ||
                         (e_s.ptaken && actual && e_s.ptarget != e_s.target));
        fill = active && actual && (!e_s.hit || e_s.ptarget != e_s.target);
        fi = btb_idx_t'(e_s.pc >> 2);
        li = btb_idx_t'(pc >> 2);
        f = '0;
        f.valid = 1'b1;
        f.pc = pc;
        f.op = op;
        f.taken = tk;
        f.target = tgt;
        if (fill && fi == li) begin
            f.hit = (e_s.pc == pc);
            jmp = (e_s.op != OP_BRANCH);
            f.ptarget = e_s.target;
        end else begin
            f.hit = m_valid[li] && (m_tag[li] == pc);
            jmp = m_jump[li];
            f.ptarget = m_tgt[li];
        end
        f.idx = ghr_t'(pc >> 2) ^ m_ghr;
        f.ptaken = f.hit && (jmp || m_ctr[f.idx] >= CTR_WEAK_T);
        pc_f_i = pc;
        stall_i = stall;
        op_e_i = e_s.valid ? e_s.op : OP_OTHER;
        taken_e_i = e_s.valid && e_s.taken;
        target_e_i = e_s.target;
        @(negedge clk);
        check("taken_o", 32'(f.ptaken), 32'(taken_o));
        if (f.ptaken)
            check("target_o", f.ptarget, target_o);
        check("mispredict_o", 32'(mis), 32'(mispredict_o));
        if (mis)
            check("redirect_pc_o", actual ? e_s.target : e_s.pc + 32'd4, redirect_pc_o);
        @(posedge clk);
        if (fill) begin
            m_valid[fi] = 1'b1;
            m_tag[fi] = e_s.pc;
            m_tgt[fi] = e_s.target;
            m_jump[fi] = (e_s.op != OP_BRANCH);
        end
        if (active && e_s.op == OP_BRANCH) begin
            if (e_s.taken && m_ctr[e_s.idx] != CTR_STRONG_T)
                m_ctr[e_s.idx] = ctr_t'(m_ctr[e_s.idx] + 2'd1);
            else if (!e_s.taken && m_ctr[e_s.idx] != CTR_STRONG_NT)
                m_ctr[e_s.idx] = ctr_t'(m_ctr[e_s.idx] - 2'd1);
            m_ghr = {m_ghr[`BP_GHR_BITS-2:0], e_s.taken};
        end
        if (mis) begin
            d_s.valid = 1'b0;
            e_s.valid = 1'b0;
        end else if (!stall) begin
            e_s = d_s;
            d_s = f;
        end
        #1;
    endtask

    task automatic nops(int n);
        for (int i = 0; i < n; i++) begin
            step(32'h8000 + 32'(nop_count % 64) * 4, OP_OTHER, 1'b0, '0, 1'b0);
            nop_count++;
        end
    endtask

    task automatic start_test(string name);
        test_name = name;
        test_err0 = errors;
        tests++;
    endtask

    task automatic end_test();
        $display("test %s done with %0d errors", test_name, errors - test_err0);
    endtask

    initial begin
        #200us;
        $display("timeout: the run did not finish");
        $display("Regression failed");
        $finish;
    end

    initial begin
        opcode_t rop;
        pc_t rpc;
        void'($urandom(32'hc0e1));
        reset_i = 1'b1;
        stall_i = 1'b0;
        pc_f_i = '0;
        op_e_i = OP_OTHER;
        taken_e_i = 1'b0;
        target_e_i = '0;
        errors = 0;
        tests = 0;
        nop_count = 0;
        m_ghr = '0;
        d_s = '0;
        e_s = '0;
        for (int i = 0; i < `BP_BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_tag[i] = '0;
            m_tgt[i] = '0;
            m_jump[i] = 1'b0;
        end
        for (int i = 0; i < (1 << `BP_GHR_BITS); i++)
            m_ctr[i] = ctr_t'(`BP_CTR_INIT);
        for (int i = 0; i < 10; i++)
            @(posedge clk);
        #1 reset_i = 1'b0;

        start_test("reset_quiet");
        for (int i = 0; i < 20; i++)
            step({$urandom} & 32'hffff_fffc, OP_OTHER, 1'b0, '0, 1'b0);
        end_test();

        start_test("jal_fill");
        step(32'h100, OP_JAL, 1'b1, 32'h2000, 1'b0);
        nops(3);
        step(32'h100, OP_JAL, 1'b1, 32'h2000, 1'b0);
        nops(2);
        step(32'h180, OP_JAL, 1'b1, 32'h3000, 1'b0);
        nops(1);
        // same index as the fill resolving in this cycle
        step(32'h180, OP_JAL, 1'b1, 32'h3000, 1'b0);
        nops(3);
        end_test();

        // long enough runs to reach correct taken predictions and a counter walking back
        start_test("branch_counter");
        for (int i = 0; i < 16; i++) begin
            step(32'h300, OP_BRANCH, i < 8, 32'h340, 1'b0);
            nops(2);
        end
        end_test();

        start_test("redirect");
        for (int i = 0; i < 4; i++) begin
            step(32'h500, OP_BRANCH, i < 3, 32'h600, 1'b0);
            nops(2);
        end
        step(32'h700, OP_JALR, 1'b1, 32'h1100, 1'b0);
        nops(2);
        step(32'h700, OP_JALR, 1'b1, 32'h1200, 1'b0);
        nops(2);
        step(32'h700, OP_JALR, 1'b1, 32'h1200, 1'b0);
        nops(2);
        end_test();

        start_test("stall_hold");
        step(32'h900, OP_JAL, 1'b1, 32'h1400, 1'b0);
        nops(1);
        for (int i = 0; i < 5; i++)
            step(32'h900, OP_OTHER, 1'b0, '0, 1'b1);
        nops(3);
        end_test();

        start_test("random_mix");
        for (int i = 0; i < 300; i++) begin
            rpc = 32'h1000 + 32'($urandom % 12) * 32'h40;
            case ($urandom % 4)
                0: rop = OP_BRANCH;
                1: rop = OP_JAL;
                2: rop = OP_JALR;
                default: rop = OP_OTHER;
            endcase
            step(rpc, rop, 1'($urandom), 32'h4000 + 32'($urandom % 3) * 4,
                 ($urandom % 8) == 0);
        end
        end_test();

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule
